/* hw/fabric_settings.svh */
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// Number of processing cores on the fabric
`define CORE_COUNT 16

// Width of a core number, log2 of the core count
`define CORE_ID_WIDTH 4

// One beat of the scheduler control stream
`define CTRL_DATA_WIDTH 64

// Core message fields
`define MSG_KIND_WIDTH 4

// Byte address into the 32 KiB data memory
`define MSG_ADDR_WIDTH 15

`define MSG_DATA_WIDTH 32

`endif

/* hw/core_msg_pkg.sv */
`include "fabric_settings.svh"

package core_msg_pkg;

  localparam int MSG_WIDTH = `MSG_KIND_WIDTH + `MSG_ADDR_WIDTH + `MSG_DATA_WIDTH;

  typedef logic [`MSG_KIND_WIDTH-1:0] msg_kind_t;
  typedef logic [`MSG_ADDR_WIDTH-1:0] msg_addr_t;
  typedef logic [`MSG_DATA_WIDTH-1:0] msg_data_t;

  // Kind in the top bits, then address, then data
  typedef logic [MSG_WIDTH-1:0] core_msg_t;

  function automatic core_msg_t make_msg(
    msg_kind_t kind,
    msg_addr_t addr,
    msg_data_t data
  );
    return {kind, addr, data};
  endfunction

endpackage

/* hw/ctrl_pkg.sv */
`include "fabric_settings.svh"

package ctrl_pkg;

  // Core number, also the destination and source tag on control beats
  typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;

  // One control beat
  typedef logic [`CTRL_DATA_WIDTH-1:0] ctrl_data_t;

  // Packet lock for the control merge
  typedef enum logic
  {
    merge_idle,
    merge_busy
  } merge_state_t;

endpackage

/* hw/rr_arbiter.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module rr_arbiter
(
  input  logic                   core_clk,
  input  logic                   core_rst,
  input  logic [`CORE_COUNT-1:0] req,
  input  logic                   advance,
  output logic [`CORE_COUNT-1:0] grant,
  output logic                   grant_any
);

  logic [`CORE_ID_WIDTH-1:0] ptr;
  logic [`CORE_ID_WIDTH-1:0] grant_idx;
  logic [`CORE_COUNT-1:0]    ptr_mask;
  logic [`CORE_COUNT-1:0]    req_hi;
  logic [`CORE_COUNT-1:0]    pick_src;

  // Requesters at or above the pointer win first, else wrap to the bottom
  always_comb
  begin
    ptr_mask = ~((`CORE_COUNT'(1) << ptr) - `CORE_COUNT'(1));
    req_hi   = req & ptr_mask;
    pick_src = (req_hi != '0) ? req_hi : req;
    // Lowest set bit
    grant    = pick_src & (~pick_src + `CORE_COUNT'(1));
  end

  assign grant_any = |req;

  always_comb
  begin
    grant_idx = '0;
    for (int i = 0; i < `CORE_COUNT; i++)
    begin
      if (grant[i])
        grant_idx = `CORE_ID_WIDTH'(i);
    end
  end

  // Priority moves to one above the grantee
  always_ff @(posedge core_clk)
  begin
    if (core_rst)
      ptr <= '0;
    else if (advance && grant_any)
    begin
      if (grant_idx == `CORE_ID_WIDTH'(`CORE_COUNT - 1))
        ptr <= '0;
      else
        ptr <= grant_idx + 1'b1;
    end
  end

  grant_onehot_a: assert property (@(posedge core_clk) disable iff (core_rst)
    $onehot0(grant) && ((grant & ~req) == '0));

endmodule

/* hw/msg_broadcast.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module msg_broadcast
(
  input  logic                                       core_clk,
  input  logic                                       core_rst,
  input  logic [`CORE_COUNT-1:0]                     msg_out_valid,
  input  core_msg_pkg::core_msg_t [`CORE_COUNT-1:0]  msg_out_data,
  output logic [`CORE_COUNT-1:0]                     msg_out_ready,
  output logic [`CORE_COUNT-1:0]                     msg_in_valid,
  output core_msg_pkg::core_msg_t                    msg_in_data
);

  import core_msg_pkg::*;

  logic [`CORE_COUNT-1:0] grant;
  logic                   grant_any;
  core_msg_t              msg_sel;
  core_msg_t              msg_r;
  logic                   msg_valid_r;
  logic [`CORE_COUNT-1:0] sender_r;

  // Cores always take messages, so the pointer moves every cycle
  rr_arbiter rr_arbiter_inst
  (
    .core_clk  (core_clk),
    .core_rst  (core_rst),
    .req       (msg_out_valid),
    .advance   (1'b1),
    .grant     (grant),
    .grant_any (grant_any)
  );

  // Accepted in the cycle it is granted
  assign msg_out_ready = grant;

  always_comb
  begin
    msg_sel = '0;
    for (int i = 0; i < `CORE_COUNT; i++)
    begin
      if (grant[i])
        msg_sel = msg_out_data[i];
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (core_rst)
    begin
      msg_valid_r <= 1'b0;
      sender_r    <= '0;
    end
    else
    begin
      msg_valid_r <= grant_any;
      sender_r    <= grant;
    end
  end

  // Payload only
  always_ff @(posedge core_clk)
  begin
    if (grant_any)
      msg_r <= msg_sel;
  end

  // Everyone but the sender sees the message for one cycle
  assign msg_in_valid = msg_valid_r ? ~sender_r : '0;
  assign msg_in_data  = msg_r;

  no_echo_a: assert property (@(posedge core_clk) disable iff (core_rst)
    (msg_in_valid & $past(msg_out_ready)) == '0);

endmodule

/* hw/ctrl_route.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module ctrl_route
(
  input  logic                   core_clk,
  input  logic                   core_rst,
  input  logic                   sched_ctrl_valid,
  input  ctrl_pkg::ctrl_data_t   sched_ctrl_data,
  input  logic                   sched_ctrl_last,
  input  ctrl_pkg::core_id_t     sched_ctrl_dest,
  output logic                   sched_ctrl_ready,
  output logic [`CORE_COUNT-1:0] core_ctrl_in_valid,
  output ctrl_pkg::ctrl_data_t   core_ctrl_in_data,
  output logic                   core_ctrl_in_last,
  input  logic [`CORE_COUNT-1:0] core_ctrl_in_ready
);

  import ctrl_pkg::*;

  logic       beat_valid;
  ctrl_data_t beat_data;
  logic       beat_last;
  core_id_t   beat_dest;
  logic       beat_taken;
  logic       in_pkt;

  assign beat_taken       = beat_valid && core_ctrl_in_ready[beat_dest];
  // Refill in the same cycle the held beat leaves
  assign sched_ctrl_ready = !beat_valid || beat_taken;

  always_ff @(posedge core_clk)
  begin
    if (core_rst)
    begin
      beat_valid <= 1'b0;
      in_pkt     <= 1'b0;
    end
    else if (sched_ctrl_ready)
    begin
      beat_valid <= sched_ctrl_valid;
      if (sched_ctrl_valid)
        in_pkt <= !sched_ctrl_last;
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (sched_ctrl_valid && sched_ctrl_ready)
    begin
      beat_data <= sched_ctrl_data;
      beat_last <= sched_ctrl_last;
      beat_dest <= sched_ctrl_dest;
    end
  end

  // Valid goes only to the destination core
  assign core_ctrl_in_valid = beat_valid ? (`CORE_COUNT'(1) << beat_dest) : '0;
  assign core_ctrl_in_data  = beat_data;
  assign core_ctrl_in_last  = beat_last;

  // beat_dest still holds the previous beat's destination here
  pkt_dest_a: assert property (@(posedge core_clk) disable iff (core_rst)
    (sched_ctrl_valid && sched_ctrl_ready && in_pkt) |-> sched_ctrl_dest == beat_dest);

endmodule

/* hw/ctrl_merge.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module ctrl_merge
(
  input  logic                                      core_clk,
  input  logic                                      core_rst,
  input  logic [`CORE_COUNT-1:0]                    core_ctrl_out_valid,
  input  ctrl_pkg::ctrl_data_t [`CORE_COUNT-1:0]    core_ctrl_out_data,
  input  logic [`CORE_COUNT-1:0]                    core_ctrl_out_last,
  output logic [`CORE_COUNT-1:0]                    core_ctrl_out_ready,
  output logic                                      sched_ctrl_out_valid,
  output ctrl_pkg::ctrl_data_t                      sched_ctrl_out_data,
  output logic                                      sched_ctrl_out_last,
  output ctrl_pkg::core_id_t                        sched_ctrl_out_src,
  input  logic                                      sched_ctrl_out_ready
);

  import ctrl_pkg::*;

  merge_state_t           state;
  logic [`CORE_COUNT-1:0] sel_r;
  logic [`CORE_COUNT-1:0] arb_req;
  logic [`CORE_COUNT-1:0] grant;
  logic                   grant_any;
  logic                   last_taken;

  // While busy only the locked core requests, so the grant holds
  assign arb_req = (state == merge_busy) ? sel_r : core_ctrl_out_valid;

  rr_arbiter rr_arbiter_inst
  (
    .core_clk  (core_clk),
    .core_rst  (core_rst),
    .req       (arb_req),
    .advance   (last_taken),
    .grant     (grant),
    .grant_any (grant_any)
  );

  // Granted input passes straight through
  always_comb
  begin
    sched_ctrl_out_data = '0;
    sched_ctrl_out_src  = '0;
    for (int i = 0; i < `CORE_COUNT; i++)
    begin
      if (grant[i])
      begin
        sched_ctrl_out_data = core_ctrl_out_data[i];
        sched_ctrl_out_src  = core_id_t'(i);
      end
    end
  end

  assign sched_ctrl_out_valid = |(core_ctrl_out_valid & grant);
  assign sched_ctrl_out_last  = |(core_ctrl_out_last & grant);
  assign core_ctrl_out_ready  = grant & {`CORE_COUNT{sched_ctrl_out_ready}};
  assign last_taken = sched_ctrl_out_valid && sched_ctrl_out_ready && sched_ctrl_out_last;

  always_ff @(posedge core_clk)
  begin
    if (core_rst)
      state <= merge_idle;
    else
    begin
      case (state)
        merge_idle:
          // Single-beat packet taken at once needs no lock
          if (grant_any && !last_taken)
            state <= merge_busy;
        merge_busy:
          if (last_taken)
            state <= merge_idle;
        default:
          state <= merge_idle;
      endcase
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (state == merge_idle && grant_any)
      sel_r <= grant;
  end

  src_locked_a: assert property (@(posedge core_clk) disable iff (core_rst)
    (state == merge_busy) |-> sched_ctrl_out_src == $past(sched_ctrl_out_src));

endmodule

/* hw/core_fabric_top.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module core_fabric_top
(
  input  logic                                      core_clk,
  input  logic                                      core_rst,

  // Core to core messages
  input  logic [`CORE_COUNT-1:0]                    msg_out_valid,
  input  core_msg_pkg::core_msg_t [`CORE_COUNT-1:0] msg_out_data,
  output logic [`CORE_COUNT-1:0]                    msg_out_ready,
  output logic [`CORE_COUNT-1:0]                    msg_in_valid,
  output core_msg_pkg::core_msg_t                   msg_in_data,

  // Scheduler control toward the cores
  input  logic                                      sched_ctrl_valid,
  input  ctrl_pkg::ctrl_data_t                      sched_ctrl_data,
  input  logic                                      sched_ctrl_last,
  input  ctrl_pkg::core_id_t                        sched_ctrl_dest,
  output logic                                      sched_ctrl_ready,
  output logic [`CORE_COUNT-1:0]                    core_ctrl_in_valid,
  output ctrl_pkg::ctrl_data_t                      core_ctrl_in_data,
  output logic                                      core_ctrl_in_last,
  input  logic [`CORE_COUNT-1:0]                    core_ctrl_in_ready,

  // Core control back to the scheduler
  input  logic [`CORE_COUNT-1:0]                    core_ctrl_out_valid,
  input  ctrl_pkg::ctrl_data_t [`CORE_COUNT-1:0]    core_ctrl_out_data,
  input  logic [`CORE_COUNT-1:0]                    core_ctrl_out_last,
  output logic [`CORE_COUNT-1:0]                    core_ctrl_out_ready,
  output logic                                      sched_ctrl_out_valid,
  output ctrl_pkg::ctrl_data_t                      sched_ctrl_out_data,
  output logic                                      sched_ctrl_out_last,
  output ctrl_pkg::core_id_t                        sched_ctrl_out_src,
  input  logic                                      sched_ctrl_out_ready
);

  msg_broadcast msg_broadcast_inst
  (
    .core_clk      (core_clk),
    .core_rst      (core_rst),
    .msg_out_valid (msg_out_valid),
    .msg_out_data  (msg_out_data),
    .msg_out_ready (msg_out_ready),
    .msg_in_valid  (msg_in_valid),
    .msg_in_data   (msg_in_data)
  );

  ctrl_route ctrl_route_inst
  (
    .core_clk           (core_clk),
    .core_rst           (core_rst),
    .sched_ctrl_valid   (sched_ctrl_valid),
    .sched_ctrl_data    (sched_ctrl_data),
    .sched_ctrl_last    (sched_ctrl_last),
    .sched_ctrl_dest    (sched_ctrl_dest),
    .sched_ctrl_ready   (sched_ctrl_ready),
    .core_ctrl_in_valid (core_ctrl_in_valid),
    .core_ctrl_in_data  (core_ctrl_in_data),
    .core_ctrl_in_last  (core_ctrl_in_last),
    .core_ctrl_in_ready (core_ctrl_in_ready)
  );

  ctrl_merge ctrl_merge_inst
  (
    .core_clk             (core_clk),
    .core_rst             (core_rst),
    .core_ctrl_out_valid  (core_ctrl_out_valid),
    .core_ctrl_out_data   (core_ctrl_out_data),
    .core_ctrl_out_last   (core_ctrl_out_last),
    .core_ctrl_out_ready  (core_ctrl_out_ready),
    .sched_ctrl_out_valid (sched_ctrl_out_valid),
    .sched_ctrl_out_data  (sched_ctrl_out_data),
    .sched_ctrl_out_last  (sched_ctrl_out_last),
    .sched_ctrl_out_src   (sched_ctrl_out_src),
    .sched_ctrl_out_ready (sched_ctrl_out_ready)
  );

endmodule

/* sim/tb_core_fabric.sv */
`timescale 1ns/10ps

`include "fabric_settings.svh"

module tb_core_fabric;

  import core_msg_pkg::*;
  import ctrl_pkg::*;

  // Several times the expected length of all tests together
  localparam int MAX_CYCLES = 2000;

  // Control beat as the models keep it
  typedef struct packed
  {
    core_id_t   dest;
    logic       last;
    ctrl_data_t data;
  } beat_t;

  logic                         core_clk;
  logic                         core_rst;
  logic [`CORE_COUNT-1:0]       msg_out_valid;
  core_msg_t [`CORE_COUNT-1:0]  msg_out_data;
  logic [`CORE_COUNT-1:0]       msg_out_ready;
  logic [`CORE_COUNT-1:0]       msg_in_valid;
  core_msg_t                    msg_in_data;
  logic                         sched_ctrl_valid;
  ctrl_data_t                   sched_ctrl_data;
  logic                         sched_ctrl_last;
  core_id_t                     sched_ctrl_dest;
  logic                         sched_ctrl_ready;
  logic [`CORE_COUNT-1:0]       core_ctrl_in_valid;
  ctrl_data_t                   core_ctrl_in_data;
  logic                         core_ctrl_in_last;
  logic [`CORE_COUNT-1:0]       core_ctrl_in_ready;
  logic [`CORE_COUNT-1:0]       core_ctrl_out_valid;
  ctrl_data_t [`CORE_COUNT-1:0] core_ctrl_out_data;
  logic [`CORE_COUNT-1:0]       core_ctrl_out_last;
  logic [`CORE_COUNT-1:0]       core_ctrl_out_ready;
  logic                         sched_ctrl_out_valid;
  ctrl_data_t                   sched_ctrl_out_data;
  logic                         sched_ctrl_out_last;
  core_id_t                     sched_ctrl_out_src;
  logic                         sched_ctrl_out_ready;

  integer                 seed;
  int                     cycle_count;
  string                  test_name;
  logic                   route_random;
  logic                   merge_random;
  // Handshakes seen at the falling edge before each rising edge
  logic [`CORE_COUNT-1:0] msg_acc;
  logic [`CORE_COUNT-1:0] merge_acc;
  logic                   route_acc;
  core_id_t               exp_ptr;
  int                     exp_win;
  logic [`CORE_COUNT-1:0] exp_grant;
  logic                   exp_msg_valid;
  logic [`CORE_COUNT-1:0] exp_sender;
  logic [`CORE_COUNT-1:0] exp_bcast;
  core_msg_t              exp_msg;
  beat_t                  route_q[$];
  beat_t                  merge_q[`CORE_COUNT][$];
  logic [`CORE_COUNT-1:0] route_mask;
  logic                   route_taken;
  logic                   pkt_open;
  core_id_t               pkt_src;
  int                     beats_left[`CORE_COUNT];
  int                     pkt_len[`CORE_COUNT];
  int                     rr_cycles;
  int                     pending;
  int                     core_i;
  core_id_t               sender;

  core_fabric_top core_fabric_top_inst (.*);

  always #10 core_clk = ~core_clk;

  always @(posedge core_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES)
      stop_with_error($sformatf("Timeout after %0d cycles", MAX_CYCLES));
  end

  task automatic stop_with_error(string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(string check, logic [63:0] expected, logic [63:0] actual);
    stop_with_error($sformatf("Mismatch in %s (%s): expected %h, actual %h",
      test_name, check, expected, actual));
  endtask

  // First requester at or above the pointer with wrap-around
  function automatic int rr_winner(logic [`CORE_COUNT-1:0] req, core_id_t ptr);
    int idx;
    for (int k = 0; k < `CORE_COUNT; k++)
    begin
      idx = (int'(ptr) + k) % `CORE_COUNT;
      if (req[idx])
        return idx;
    end
    return -1;
  endfunction

  task automatic next_cycle();
    @(posedge core_clk);
    #2;
    msg_out_valid = msg_out_valid & ~msg_acc;
    if (route_random)
      core_ctrl_in_ready = `CORE_COUNT'($random(seed));
    if (merge_random)
      sched_ctrl_out_ready = 1'($random(seed));
  endtask

  task automatic send_route_pkt(core_id_t dest, int beats);
    for (int b = 0; b < beats; b++)
    begin
      sched_ctrl_valid = 1'b1;
      sched_ctrl_data  = {$random(seed), $random(seed)};
      sched_ctrl_last  = (b == beats - 1);
      sched_ctrl_dest  = dest;
      do
        next_cycle();
      while (!route_acc);
    end
    sched_ctrl_valid = 1'b0;
  endtask

  task automatic load_merge_beat(int core);
    beat_t beat;
    beat.dest = core_id_t'(core);
    beat.last = (beats_left[core] % pkt_len[core]) == 1;
    beat.data = {$random(seed), $random(seed)};
    core_ctrl_out_valid[core] = 1'b1;
    core_ctrl_out_data[core]  = beat.data;
    core_ctrl_out_last[core]  = beat.last;
    merge_q[core].push_back(beat);
  endtask

  // Round-robin scoreboard for the message path
  assign exp_win   = rr_winner(msg_out_valid, exp_ptr);
  assign exp_grant = (exp_win < 0) ? '0 : (`CORE_COUNT'(1) << exp_win);
  assign exp_bcast = exp_msg_valid ? ~exp_sender : '0;

  always @(negedge core_clk)
  begin
    msg_acc   <= msg_out_valid & msg_out_ready;
    merge_acc <= core_ctrl_out_valid & core_ctrl_out_ready;
    route_acc <= sched_ctrl_valid && sched_ctrl_ready;
    if (core_rst)
    begin
      exp_ptr       <= '0;
      exp_msg_valid <= 1'b0;
    end
    else
    begin
      exp_msg_valid <= (exp_win >= 0);
      exp_sender    <= exp_grant;
      if (exp_win >= 0)
      begin
        exp_msg <= msg_out_data[exp_win];
        exp_ptr <= core_id_t'(exp_win + 1);
      end
    end
  end

  rr_grant_a: assert property (@(negedge core_clk) disable iff (core_rst)
    msg_out_ready == exp_grant)
    else report_mismatch("grant", $sampled(exp_grant), $sampled(msg_out_ready));

  bcast_valid_a: assert property (@(negedge core_clk) disable iff (core_rst)
    msg_in_valid == exp_bcast)
    else report_mismatch("broadcast valid", $sampled(exp_bcast), $sampled(msg_in_valid));

  bcast_data_a: assert property (@(negedge core_clk) disable iff (core_rst)
    exp_msg_valid |-> msg_in_data == exp_msg)
    else report_mismatch("broadcast data", $sampled(exp_msg), $sampled(msg_in_data));

  merge_lock_a: assert property (@(negedge core_clk) disable iff (core_rst)
    (pkt_open && sched_ctrl_out_valid) |-> sched_ctrl_out_src == pkt_src)
    else report_mismatch("packet source", $sampled(pkt_src), $sampled(sched_ctrl_out_src));

  merge_stall_a: assert property (@(negedge core_clk) disable iff (core_rst)
    (core_ctrl_out_ready & ~(`CORE_COUNT'(1) << sched_ctrl_out_src)) == '0)
    else stop_with_error("A core other than the granted one saw ready on the merge");

  // Route model keeps one queue in acceptance order
  always @(negedge core_clk)
  begin
    if (core_rst)
      route_q.delete();
    else
    begin
      route_mask  = '0;
      route_taken = 1'b0;
      if (route_q.size() != 0)
      begin
        route_mask  = `CORE_COUNT'(1) << route_q[0].dest;
        route_taken = core_ctrl_in_ready[route_q[0].dest];
      end
      route_valid_a: assert (core_ctrl_in_valid == route_mask)
        else report_mismatch("destination valid", route_mask, core_ctrl_in_valid);
      route_ready_a: assert (sched_ctrl_ready == (route_q.size() == 0 || route_taken))
        else report_mismatch("scheduler ready", (route_q.size() == 0 || route_taken),
          sched_ctrl_ready);
      if (route_taken)
      begin
        route_data_a: assert (core_ctrl_in_data == route_q[0].data)
          else report_mismatch("routed data", route_q[0].data, core_ctrl_in_data);
        route_last_a: assert (core_ctrl_in_last == route_q[0].last)
          else report_mismatch("routed last", route_q[0].last, core_ctrl_in_last);
        void'(route_q.pop_front());
      end
      if (sched_ctrl_valid && sched_ctrl_ready)
        route_q.push_back(beat_t'({sched_ctrl_dest, sched_ctrl_last, sched_ctrl_data}));
    end
  end

  // Merge model with one queue per core
  always @(negedge core_clk)
  begin
    if (core_rst)
      pkt_open <= 1'b0;
    else if (sched_ctrl_out_valid && sched_ctrl_out_ready)
    begin
      pkt_open <= !sched_ctrl_out_last;
      pkt_src  <= sched_ctrl_out_src;
      if (merge_q[sched_ctrl_out_src].size() == 0)
        stop_with_error("Merged beat names a core with no beat pending");
      else
      begin
        merge_data_a: assert (sched_ctrl_out_data == merge_q[sched_ctrl_out_src][0].data)
          else report_mismatch("merged data", merge_q[sched_ctrl_out_src][0].data,
            sched_ctrl_out_data);
        merge_last_a: assert (sched_ctrl_out_last == merge_q[sched_ctrl_out_src][0].last)
          else report_mismatch("merged last", merge_q[sched_ctrl_out_src][0].last,
            sched_ctrl_out_last);
        void'(merge_q[sched_ctrl_out_src].pop_front());
      end
    end
  end

  initial
  begin
    seed                 = 25;
    cycle_count          = 0;
    core_clk             = 1'b0;
    core_rst             = 1'b1;
    msg_out_valid        = '0;
    msg_out_data         = '0;
    sched_ctrl_valid     = 1'b0;
    sched_ctrl_data      = '0;
    sched_ctrl_last      = 1'b0;
    sched_ctrl_dest      = '0;
    core_ctrl_in_ready   = '0;
    core_ctrl_out_valid  = '0;
    core_ctrl_out_data   = '0;
    core_ctrl_out_last   = '0;
    sched_ctrl_out_ready = 1'b0;
    route_random         = 1'b0;
    merge_random         = 1'b0;
    test_name            = "reset";
    repeat (3) @(posedge core_clk);
    #2;
    core_rst = 1'b0;
    @(negedge core_clk);
    reset_a: assert ({msg_in_valid, core_ctrl_in_valid, sched_ctrl_out_valid} == '0)
      else report_mismatch("valid outputs", '0,
        {msg_in_valid, core_ctrl_in_valid, sched_ctrl_out_valid});

    // Every core requests at once while the pointer is still at core 0
    test_name = "round_robin";
    next_cycle();
    for (int i = 0; i < `CORE_COUNT; i++)
      msg_out_data[i] = core_msg_t'({$random(seed), $random(seed)});
    msg_out_valid = '1;
    rr_cycles = 0;
    while (msg_out_valid != '0)
    begin
      next_cycle();
      rr_cycles++;
    end
    rr_count_a: assert (rr_cycles == `CORE_COUNT)
      else report_mismatch("cycles to drain", `CORE_COUNT, rr_cycles);

    test_name = "sender_excluded";
    repeat (4)
    begin
      sender = core_id_t'($random(seed));
      msg_out_data[sender]  = core_msg_t'({$random(seed), $random(seed)});
      msg_out_valid[sender] = 1'b1;
      while (msg_out_valid != '0)
        next_cycle();
    end
    next_cycle();

    test_name = "routing";
    core_ctrl_in_ready = '1;
    repeat (12)
      send_route_pkt(core_id_t'($random(seed)), 1 + int'($unsigned($random(seed)) % 3));
    while (route_q.size() != 0)
      next_cycle();

    test_name    = "route_backpressure";
    route_random = 1'b1;
    repeat (12)
      send_route_pkt(core_id_t'($random(seed)), 1 + int'($unsigned($random(seed)) % 3));
    while (route_q.size() != 0)
      next_cycle();
    route_random = 1'b0;

    // Three cores send two packets each of 2 to 4 beats
    test_name    = "merging";
    merge_random = 1'b1;
    sender       = core_id_t'($random(seed));
    for (int k = 0; k < 3; k++)
    begin
      core_i             = int'(core_id_t'(sender + 5 * k));
      pkt_len[core_i]    = 2 + k;
      beats_left[core_i] = 2 * pkt_len[core_i];
      load_merge_beat(core_i);
    end
    while (core_ctrl_out_valid != '0)
    begin
      next_cycle();
      for (int i = 0; i < `CORE_COUNT; i++)
      begin
        if (merge_acc[i])
        begin
          beats_left[i]--;
          if (beats_left[i] == 0)
            core_ctrl_out_valid[i] = 1'b0;
          else
            load_merge_beat(i);
        end
      end
    end

    pending = route_q.size();
    for (int i = 0; i < `CORE_COUNT; i++)
      pending += merge_q[i].size();
    if (pending != 0)
      stop_with_error($sformatf("%0d control beats were never delivered", pending));
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* compile.f */
+incdir+hw
hw/core_msg_pkg.sv
hw/ctrl_pkg.sv
hw/rr_arbiter.sv
hw/msg_broadcast.sv
hw/ctrl_route.sv
hw/ctrl_merge.sv
hw/core_fabric_top.sv
sim/tb_core_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_core_fabric \
  -o sim_core_fabric

# A failing check ends in $fatal, so a nonzero exit status means failure
./obj_dir/sim_core_fabric
